// File: include/predictor_consts.svh
`ifndef PREDICTOR_CONSTS_SVH
`define PREDICTOR_CONSTS_SVH

// Direction counter width, 1 or 2
`define PRED_BITS 2

// Buffer depth, power of two
`define NFRAMES 32

// RV32I data and address width
`define WORD_SIZE 32

// Tag and counter share one byte per frame
`define TAG_BITS (8 - `PRED_BITS)

`define SET_BITS $clog2(`NFRAMES) // Index width

// First fetch address out of reset
`define RESET_PC 32'h0000_0200

`endif

// File: hw/rv32i_types_pkg.sv
`include "predictor_consts.svh"

package rv32i_types_pkg;

    // Bits of the PC above the tag
    localparam int IGNORE_BITS = `WORD_SIZE - `TAG_BITS - `SET_BITS - 1;

    typedef logic [`WORD_SIZE-1:0] word_t; // Data or address word

    // PC split for the target buffer
    typedef struct packed {
        logic [IGNORE_BITS-1:0] ignore_bits; // Not stored
        logic [`TAG_BITS-1:0]   tag_bits;    // Compared against frame tag
        logic [`SET_BITS-1:0]   idx_bits;    // Frame select
        logic                   byte_bit;    // 2-byte alignment, unused
    } btb_addr_t;

    // Same PC seen as plain word or as buffer fields
    typedef union packed {
        word_t     word;
        btb_addr_t btb;
    } pc_u;

endpackage

// File: hw/predictor_pkg.sv
`include "predictor_consts.svh"

package predictor_pkg;

    // Two-bit direction counter
    // High bit gives the taken prediction
    typedef enum logic [1:0] {
        SNT = 2'b00, // Strongly not taken
        WNT = 2'b01, // Weakly not taken
        WT  = 2'b10, // Weakly taken
        ST  = 2'b11  // Strongly taken
    } ctr_state_t;

    // One buffer entry
    typedef struct packed {
        logic [`TAG_BITS-1:0]   tag;    // Upper PC bits of owner
        rv32i_types_pkg::word_t target; // Last resolved target
        logic [`PRED_BITS-1:0]  taken;  // Direction counter
    } btb_frame_t;

endpackage

// File: hw/btb.sv
`timescale 1ns/1ps
`include "predictor_consts.svh"

module btb (
    input  logic                   CLK,
    input  logic                   nRST,
    input  rv32i_types_pkg::word_t current_pc,
    input  logic                   is_branch,
    input  logic                   update_predictor,
    input  rv32i_types_pkg::word_t pc_to_update,
    input  rv32i_types_pkg::word_t update_addr,
    input  logic                   branch_result,
    output logic                   predict_taken,
    output rv32i_types_pkg::word_t target_addr
);
    import rv32i_types_pkg::*;
    import predictor_pkg::*;

    btb_frame_t [`NFRAMES-1:0] buffer; // Frame storage

    pc_u cur_pc;   // Fetch side decode
    pc_u upd_pc;   // Training side decode

    btb_frame_t sel_frame;  // Frame under the fetch PC
    btb_frame_t upd_frame;  // Old contents of the trained frame
    btb_frame_t next_frame; // Frame written at the next edge

    logic [`PRED_BITS-1:0] next_taken; // Trained counter value
    logic                  tag_hit;

    assign cur_pc.word = current_pc;
    assign upd_pc.word = pc_to_update;

    assign sel_frame = buffer[cur_pc.btb.idx_bits];
    assign upd_frame = buffer[upd_pc.btb.idx_bits];

    // Counter training
    if (`PRED_BITS == 1) begin : g_one_bit
        // Single bit just remembers last outcome
        assign next_taken = branch_result;
    end else begin : g_two_bit
        ctr_state_t cur_state;
        ctr_state_t nxt_state;

        always_comb begin
            cur_state = ctr_state_t'(upd_frame.taken);
            case (cur_state)
                SNT:     nxt_state = branch_result ? WNT : SNT;
                WNT:     nxt_state = branch_result ? ST  : SNT; // Jumps straight to strong
                WT:      nxt_state = branch_result ? ST  : SNT;
                ST:      nxt_state = branch_result ? ST  : WT;
                default: nxt_state = SNT;
            endcase
        end

        assign next_taken = nxt_state;
    end

    // New tag and target replace the old owner
    always_comb begin
        next_frame.tag    = upd_pc.btb.tag_bits;
        next_frame.target = update_addr;
        next_frame.taken  = next_taken;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            buffer <= '0; // Tag 0, counter SNT
        end else if (update_predictor) begin
            buffer[upd_pc.btb.idx_bits] <= next_frame;
        end
    end

    // Combinational lookup in the same cycle as pc
    assign tag_hit = (sel_frame.tag == cur_pc.btb.tag_bits);

    // Taken only for a real branch that owns the frame
    assign predict_taken = tag_hit && is_branch && sel_frame.taken[`PRED_BITS-1];

    assign target_addr = sel_frame.target; // Shown even on a miss

endmodule

// File: hw/fetch_pc_gen.sv
`timescale 1ns/1ps
`include "predictor_consts.svh"

module fetch_pc_gen (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   stall,
    input  logic                   predict_taken,
    input  rv32i_types_pkg::word_t predict_target,
    input  logic                   redirect,
    input  rv32i_types_pkg::word_t redirect_pc,
    output rv32i_types_pkg::word_t pc
);

    // Fetch PC register
    // Redirect beats stall, stall beats prediction
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;      // Mispredict recovery
        end else if (stall) begin
            pc <= pc;               // Frozen by back-pressure
        end else if (predict_taken) begin
            pc <= predict_target;   // Follow the buffer
        end else begin
            pc <= pc + 32'd4;       // Sequential fetch
        end
    end

endmodule

// File: hw/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   resolve_valid,
    input  rv32i_types_pkg::word_t resolve_pc,
    input  logic                   resolve_taken,
    input  rv32i_types_pkg::word_t resolve_target,
    input  logic                   resolve_pred_taken,
    input  rv32i_types_pkg::word_t resolve_pred_target,
    output logic                   update_predictor,
    output rv32i_types_pkg::word_t pc_to_update,
    output rv32i_types_pkg::word_t update_addr,
    output logic                   branch_result,
    output logic                   redirect,
    output rv32i_types_pkg::word_t redirect_pc,
    output logic                   mispredict
);
    import rv32i_types_pkg::*;

    logic  dir_wrong;   // Direction differs
    logic  tgt_wrong;   // Taken both ways, target differs
    logic  mispredict_c;
    word_t correct_pc;  // Where fetch should have gone

    assign dir_wrong    = (resolve_taken != resolve_pred_taken);
    assign tgt_wrong    = resolve_taken && resolve_pred_taken &&
                          (resolve_target != resolve_pred_target);
    assign mispredict_c = resolve_valid && (dir_wrong || tgt_wrong);

    // Fall-through is the next 4-byte instruction
    assign correct_pc = resolve_taken ? resolve_target : resolve_pc + 32'd4;

    // Strobes, one cycle after resolve_valid
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            update_predictor <= 1'b0;
            redirect         <= 1'b0;
        end else begin
            update_predictor <= resolve_valid; // Train on every branch
            redirect         <= mispredict_c;
        end
    end

    // Payload follows the strobes
    always_ff @(posedge CLK) begin
        pc_to_update  <= resolve_pc;
        update_addr   <= resolve_target;
        branch_result <= resolve_taken;
        redirect_pc   <= correct_pc;
    end

    assign mispredict = redirect; // Same pulse, seen outside

endmodule

// File: hw/branch_predict_top.sv
`timescale 1ns/1ps

module branch_predict_top (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   stall,
    input  logic                   is_branch,
    input  logic                   resolve_valid,
    input  rv32i_types_pkg::word_t resolve_pc,
    input  logic                   resolve_taken,
    input  rv32i_types_pkg::word_t resolve_target,
    input  logic                   resolve_pred_taken,
    input  rv32i_types_pkg::word_t resolve_pred_target,
    output rv32i_types_pkg::word_t pc,
    output logic                   predict_taken,
    output rv32i_types_pkg::word_t predict_target,
    output logic                   mispredict
);
    import rv32i_types_pkg::*;

    // Training path, resolver to buffer
    logic  update_predictor;
    word_t pc_to_update;
    word_t update_addr;
    logic  branch_result;

    // Recovery path, resolver to sequencer
    logic  redirect;
    word_t redirect_pc;

    fetch_pc_gen pc_gen_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .stall          (stall),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .pc             (pc)
    );

    btb btb_i (
        .CLK              (CLK),
        .nRST             (nRST),
        .current_pc       (pc),
        .is_branch        (is_branch),
        .update_predictor (update_predictor),
        .pc_to_update     (pc_to_update),
        .update_addr      (update_addr),
        .branch_result    (branch_result),
        .predict_taken    (predict_taken),
        .target_addr      (predict_target) // Fed back to the sequencer too
    );

    branch_resolver resolver_i (
        .CLK                 (CLK),
        .nRST                (nRST),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .update_predictor    (update_predictor),
        .pc_to_update        (pc_to_update),
        .update_addr         (update_addr),
        .branch_result       (branch_result),
        .redirect            (redirect),
        .redirect_pc         (redirect_pc),
        .mispredict          (mispredict)
    );

endmodule

// File: testbench/branch_predict_tb.sv
`timescale 1ns/1ps
`include "predictor_consts.svh"

module branch_predict_tb;
    import rv32i_types_pkg::*;
    import predictor_pkg::*;

    // Two branches on index 4, tags 13 and 14
    localparam word_t BR_B     = 32'h0000_0348;
    localparam word_t BR_A     = 32'h0000_0388;
    localparam word_t TGT_B    = 32'h0000_0800;
    localparam word_t TGT_A    = 32'h0000_0900;
    localparam word_t STEER_PC = 32'h0000_0100; // Index 0, tag 4, never fetched

    // One cycle of stimulus and what the DUT shows during it
    typedef struct packed {
        logic  rv;       // resolve_valid
        word_t rpc;      // resolve_pc
        logic  rtk;      // resolve_taken
        word_t rtgt;     // resolve_target
        logic  rptk;     // resolve_pred_taken
        word_t rptgt;    // resolve_pred_target
        logic  st;       // stall
        logic  br;       // is_branch
        word_t exp_pc;
        logic  exp_pt;
        word_t exp_ptgt;
        logic  exp_mp;
    } stim_row_t;

    logic  CLK;
    logic  nRST;
    logic  stall;
    logic  is_branch;
    logic  resolve_valid;
    word_t resolve_pc;
    logic  resolve_taken;
    word_t resolve_target;
    logic  resolve_pred_taken;
    word_t resolve_pred_target;
    word_t pc;
    logic  predict_taken;
    word_t predict_target;
    logic  mispredict;

    stim_row_t table_q[$];
    int        error_count;
    int        check_count;

    // Reference model state
    btb_frame_t m_frames [`NFRAMES];
    word_t      m_pc;
    logic       m_upd;       // Training strobe in flight
    word_t      m_upd_pc;
    word_t      m_upd_tgt;
    logic       m_upd_res;
    logic       m_redir;     // Redirect strobe in flight
    word_t      m_redir_pc;

    branch_predict_top dut_i (
        .CLK                 (CLK),
        .nRST                (nRST),
        .stall               (stall),
        .is_branch           (is_branch),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .pc                  (pc),
        .predict_taken       (predict_taken),
        .predict_target      (predict_target),
        .mispredict          (mispredict)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK; // 100 ns period
    end

    // Hard stop in case the run never reaches its end
    initial begin
        #1_000_000;
        $display("Timeout: simulation ran past 1 ms without finishing");
        $display("TEST FAILED");
        $finish;
    end

    // Taken pushes the counter up and not taken pulls it down
    function automatic logic [`PRED_BITS-1:0] next_counter(
        input logic [`PRED_BITS-1:0] ctr, input logic taken);
        ctr_state_t s;
        ctr_state_t n;
        if (`PRED_BITS == 1) return {`PRED_BITS{taken}}; // Last outcome only
        s = ctr_state_t'(ctr);
        if (taken) begin
            n = (s == SNT) ? WNT : ST; // WNT and WT both jump to ST
        end else begin
            n = (s == ST) ? WT : SNT;  // Only ST softens
        end
        return n;
    endfunction

    function automatic logic lookup_taken(input word_t pc_w, input logic br);
        pc_u        p;
        btb_frame_t f;
        p.word = pc_w;
        f = m_frames[p.btb.idx_bits];
        return br && (f.tag == p.btb.tag_bits) && f.taken[`PRED_BITS-1];
    endfunction

    function automatic word_t lookup_target(input word_t pc_w);
        pc_u p;
        p.word = pc_w;
        return m_frames[p.btb.idx_bits].target; // Shown on hit or miss
    endfunction

    // One rising edge of the model with r as the row held before it
    task automatic advance_model(input stim_row_t r);
        pc_u        up;
        btb_frame_t f;
        word_t      next_pc;
        logic       wrong;
        if (m_redir)
            next_pc = m_redir_pc;            // Wins over stall
        else if (r.st)
            next_pc = m_pc;
        else if (lookup_taken(m_pc, r.br))
            next_pc = lookup_target(m_pc);
        else
            next_pc = m_pc + 32'd4;
        if (m_upd) begin
            up.word  = m_upd_pc;
            f        = m_frames[up.btb.idx_bits]; // Old counter carries over
            f.tag    = up.btb.tag_bits;
            f.target = m_upd_tgt;
            f.taken  = next_counter(f.taken, m_upd_res);
            m_frames[up.btb.idx_bits] = f;
        end
        wrong      = (r.rtk != r.rptk) || (r.rtk && r.rptk && (r.rtgt != r.rptgt));
        m_redir    = r.rv && wrong;
        m_redir_pc = r.rtk ? r.rtgt : r.rpc + 32'd4;
        m_upd      = r.rv;                   // Every resolved branch trains
        m_upd_pc   = r.rpc;
        m_upd_tgt  = r.rtgt;
        m_upd_res  = r.rtk;
        m_pc       = next_pc;
    endtask

    task automatic push_row(input logic rv, input word_t rpc, input logic rtk,
                            input word_t rtgt, input logic rptk, input word_t rptgt,
                            input logic st, input logic br);
        stim_row_t r;
        r       = '0;
        r.rv    = rv;
        r.rpc   = rpc;
        r.rtk   = rtk;
        r.rtgt  = rtgt;
        r.rptk  = rptk;
        r.rptgt = rptgt;
        r.st    = st;
        r.br    = br;
        table_q.push_back(r);
    endtask

    task automatic idle_rows(input int n, input logic st, input logic br);
        repeat (n) push_row(1'b0, '0, 1'b0, '0, 1'b0, '0, st, br);
    endtask

    // Mispredicted taken branch lands fetch on dest and stall parks it there
    task automatic steer_fetch(input word_t dest, input int hold, input logic br);
        push_row(1'b1, STEER_PC, 1'b1, dest, 1'b0, '0, 1'b1, br);
        idle_rows(hold, 1'b1, br);
    endtask

    task automatic random_rows(input int n);
        logic [31:0] r;
        word_t       tgt;
        repeat (n) begin
            r   = $urandom();
            tgt = r[3] ? TGT_B : TGT_A;
            push_row(r[0], r[1] ? BR_B : BR_A, r[2], tgt, r[4],
                     r[7] ? tgt : TGT_B + 32'd8, r[5], r[6]);
        end
    endtask

    task automatic build_table();
        idle_rows(4, 1'b0, 1'b0);            // Sequential fetch
        idle_rows(3, 1'b1, 1'b0);            // Stall holds pc
        idle_rows(2, 1'b0, 1'b0);
        // Install B at SNT and train it through WNT to ST
        push_row(1'b1, BR_B, 1'b0, TGT_B, 1'b0, TGT_B, 1'b0, 1'b0);
        idle_rows(2, 1'b0, 1'b0);
        push_row(1'b1, BR_B, 1'b1, TGT_B, 1'b1, TGT_B, 1'b0, 1'b0);
        idle_rows(2, 1'b0, 1'b0);
        steer_fetch(BR_B, 2, 1'b1);          // WNT predicts not taken
        push_row(1'b1, BR_B, 1'b1, TGT_B, 1'b1, TGT_B, 1'b0, 1'b0);
        idle_rows(2, 1'b0, 1'b0);
        steer_fetch(BR_B, 4, 1'b1);          // Predicted taken at B
        idle_rows(1, 1'b0, 1'b1);            // Jump to TGT_B next edge
        idle_rows(2, 1'b0, 1'b0);
        // ST to WT with recovery to B + 4 under stall
        push_row(1'b1, BR_B, 1'b0, TGT_B, 1'b1, TGT_B, 1'b1, 1'b0);
        idle_rows(3, 1'b1, 1'b0);
        idle_rows(1, 1'b0, 1'b0);
        steer_fetch(BR_B, 4, 1'b1);          // WT still taken
        idle_rows(1, 1'b0, 1'b1);
        idle_rows(2, 1'b0, 1'b0);
        push_row(1'b1, BR_B, 1'b0, TGT_B, 1'b1, TGT_B, 1'b0, 1'b0); // WT to SNT
        idle_rows(3, 1'b0, 1'b0);
        steer_fetch(BR_B, 4, 1'b1);          // Now not taken
        idle_rows(1, 1'b0, 1'b1);
        idle_rows(2, 1'b0, 1'b0);
        // A evicts B and B evicts A in turn
        push_row(1'b1, BR_A, 1'b1, TGT_A, 1'b1, TGT_A, 1'b0, 1'b0);
        idle_rows(2, 1'b0, 1'b0);
        steer_fetch(BR_B, 4, 1'b1);          // Tag miss still showing TGT_A
        idle_rows(2, 1'b0, 1'b0);
        push_row(1'b1, BR_B, 1'b1, TGT_B, 1'b1, TGT_B, 1'b0, 1'b0);
        idle_rows(2, 1'b0, 1'b0);
        steer_fetch(BR_A, 4, 1'b1);
        idle_rows(2, 1'b0, 1'b0);
        // Hit on ST frame but no branch at pc
        steer_fetch(BR_B, 4, 1'b0);
        idle_rows(1, 1'b0, 1'b0);
        idle_rows(2, 1'b0, 1'b0);
        // Right direction with a wrong target
        push_row(1'b1, BR_B, 1'b1, TGT_A, 1'b1, TGT_B, 1'b0, 1'b0);
        idle_rows(3, 1'b0, 1'b0);
        random_rows(16);
        idle_rows(3, 1'b0, 1'b0);
    endtask

    // Model run over the table starting at the first edge after reset release
    task automatic fill_expected();
        stim_row_t prev;
        stim_row_t r;
        foreach (m_frames[k]) m_frames[k] = '0;
        m_pc       = `RESET_PC;
        m_upd      = 1'b0;
        m_upd_pc   = '0;
        m_upd_tgt  = '0;
        m_upd_res  = 1'b0;
        m_redir    = 1'b0;
        m_redir_pc = '0;
        prev       = '0;
        for (int i = 0; i < table_q.size(); i++) begin
            advance_model(prev);
            r          = table_q[i];
            r.exp_pc   = m_pc;
            r.exp_pt   = lookup_taken(m_pc, r.br);
            r.exp_ptgt = lookup_target(m_pc);
            r.exp_mp   = m_redir;
            table_q[i] = r;
            prev       = r;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp,
                              input int row);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL row %0d %s: got %h expected %h", row, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp,
                             input int row);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL row %0d %s: got %h expected %h", row, name, got, exp);
        end
    endtask

    initial begin
        stim_row_t   cur;
        int          waited;
        int          i;

        error_count         = 0;
        check_count         = 0;
        nRST                = 1'b0;
        stall               = 1'b0;
        is_branch           = 1'b0;
        resolve_valid       = 1'b0;
        resolve_pc          = '0;
        resolve_taken       = 1'b0;
        resolve_target      = '0;
        resolve_pred_taken  = 1'b0;
        resolve_pred_target = '0;
        void'($urandom(32'hf1af_cf19)); // Seeds all later draws
        build_table();
        fill_expected();

        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_word("pc", pc, `RESET_PC, 0);
        check_bit("predict_taken", predict_taken, 1'b0, 0);
        check_bit("mispredict", mispredict, 1'b0, 0);

        for (i = 0; i < table_q.size(); i++) begin
            cur = table_q[i];
            @(posedge CLK);
            resolve_valid       <= cur.rv;
            resolve_pc          <= cur.rpc;
            resolve_taken       <= cur.rtk;
            resolve_target      <= cur.rtgt;
            resolve_pred_taken  <= cur.rptk;
            resolve_pred_target <= cur.rptgt;
            stall               <= cur.st;
            is_branch           <= cur.br;
            @(negedge CLK);                  // Outputs settled mid-cycle
            check_word("pc", pc, cur.exp_pc, i + 1);
            check_bit("predict_taken", predict_taken, cur.exp_pt, i + 1);
            check_word("predict_target", predict_target, cur.exp_ptgt, i + 1);
            check_bit("mispredict", mispredict, cur.exp_mp, i + 1);
        end

        // Last redirect must clear after the table
        @(posedge CLK);
        resolve_valid <= 1'b0;
        stall         <= 1'b0;
        is_branch     <= 1'b0;
        @(negedge CLK);
        waited = 0;
        while (mispredict !== 1'b0 && waited < 8) begin
            @(negedge CLK);
            waited++;
        end
        if (mispredict !== 1'b0) begin
            error_count++;
            $display("Timeout: mispredict still high 8 cycles after the last row");
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hw/rv32i_types_pkg.sv
hw/predictor_pkg.sv
hw/btb.sv
hw/fetch_pc_gen.sv
hw/branch_resolver.sv
hw/branch_predict_top.sv
testbench/branch_predict_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
    --top-module branch_predict_tb -o branch_predict_sim

out=$(./obj_dir/branch_predict_sim)
echo "$out"

# Exit status comes from the search
echo "$out" | grep -qx "TEST PASSED"
